// File: rp_ps_bus.f
+incdir+verilog
verilog/rp_axi_pkg.sv
verilog/rp_sys_pkg.sv
verilog/sys_bus_if.sv
verilog/axi_slave_bridge.sv
verilog/sys_bus_decode.sv
verilog/hk_regs.sv
verilog/rp_ps_bus.sv
bench/rp_ps_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PS bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f rp_ps_bus.f \
  --top-module rp_ps_bus_tb -o rp_ps_bus_sim

status=0
./obj_dir/rp_ps_bus_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// File: bench/rp_ps_bus_tb.sv
/*
 * Testbench for the PS bus subsystem
 * AXI driver tasks, register model and response checker
 */

`include "rp_params.svh"

module rp_ps_bus_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 100;
  // Address bits above the region field give base 0x4000_0000
  localparam logic [8:0] BASE_HI = 9'h080;
  // Register offsets and AXI response codes
  localparam logic [19:0] OFF_ID = 20'h00000;
  localparam logic [19:0] OFF_SCRATCH = 20'h00004;
  localparam logic [19:0] OFF_LED = 20'h00008;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic clk_i, rst_i;
  logic [`RP_IW-1:0] awid_i, arid_i, bid_o, rid_o;
  logic [`RP_AW-1:0] awaddr_i, araddr_i;
  logic [`RP_DW-1:0] wdata_i, rdata_o;
  logic [`RP_DW/8-1:0] wstrb_i;
  logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic arvalid_i, arready_o, rvalid_o, rready_i;
  logic [1:0] bresp_o, rresp_o;
  logic [`RP_LED_W-1:0] led_o;

  // Register model
  logic [31:0] m_scratch;
  logic [7:0] m_led;

  // Pending checks filled by the drivers and drained by the compare process
  string q_what[$];
  logic [31:0] q_exp[$];
  logic [31:0] q_got[$];
  int checks, errors, seed;

  rp_ps_bus uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Model and helpers
  ////////////////////

  function automatic logic [31:0] hk_addr(input logic [2:0] region, input logic [19:0] off);
    return {BASE_HI, region, off};
  endfunction

  function automatic int rand_stall();
    return 1 + int'($unsigned($random(seed)) % 32'd8);
  endfunction

  // Expected rdata and resp of one access
  // Writes also update the model
  function automatic void ref_access(input logic wr, input logic [31:0] addr,
      input logic [31:0] data, input logic [3:0] strb,
      output logic [31:0] exp_data, output logic [1:0] exp_resp);
    int b;
    exp_data = '0;
    exp_resp = RESP_OKAY;
    if (addr[22:20] != 3'd0) begin
      exp_resp = RESP_SLVERR;
    end else if (wr) begin
      if (addr[19:0] == OFF_SCRATCH) begin
        for (b = 0; b < 4; b++) begin
          if (strb[b])
            m_scratch[8*b +: 8] = data[8*b +: 8];
        end
      end else if (addr[19:0] == OFF_LED && strb[0]) begin
        m_led = data[7:0];
      end
    end else begin
      case (addr[19:0])
        OFF_ID:      exp_data = `RP_HK_ID;
        OFF_SCRATCH: exp_data = m_scratch;
        OFF_LED:     exp_data = {24'h0, m_led};
        default:     exp_data = '0;
      endcase
    end
  endfunction

  task automatic queue_check(input string what, input logic [31:0] exp, input logic [31:0] got);
    q_what.push_back(what);
    q_exp.push_back(exp);
    q_got.push_back(got);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: no %s within %0d cycles at %0d ns", what, TIMEOUT, $time);
    $display("Test failed");
    $finish;
  endtask

  ////////////////////
  // AXI driver
  ////////////////////

  // Polls 2 ns after the falling edge
  // Handshake follows on the next rising edge
  task automatic wait_ready(input logic is_read, input string what);
    int n;
    n = 0;
    #2;
    while (!(is_read ? arready_o : (awready_o && wready_o))) begin
      n++;
      if (n > TIMEOUT)
        timeout_abort(what);
      @(negedge clk_i);
      #2;
    end
  endtask

  task automatic wait_resp(input logic is_read, input logic [11:0] id,
      input logic [31:0] exp_data, input logic [1:0] exp_resp, input int stall);
    int n;
    string what;
    logic [11:0] id0;
    logic [1:0] resp0;
    logic [31:0] data0;
    n = 0;
    what = is_read ? "rvalid" : "bvalid";
    while (!(is_read ? rvalid_o : bvalid_o)) begin
      n++;
      if (n > TIMEOUT)
        timeout_abort(what);
      @(negedge clk_i);
    end
    id0 = is_read ? rid_o : bid_o;
    resp0 = is_read ? rresp_o : bresp_o;
    data0 = rdata_o;
    // Response must not move while the master holds off
    repeat (stall) begin
      @(negedge clk_i);
      queue_check("valid held", 32'd1, 32'(is_read ? rvalid_o : bvalid_o));
      queue_check("id held", 32'(id0), 32'(is_read ? rid_o : bid_o));
      queue_check("resp held", 32'(resp0), 32'(is_read ? rresp_o : bresp_o));
      if (is_read)
        queue_check("rdata held", data0, rdata_o);
    end
    queue_check("response id", 32'(id), 32'(id0));
    queue_check("response code", 32'(exp_resp), 32'(resp0));
    if (is_read)
      queue_check("read data", exp_data, data0);
    if (is_read)
      rready_i = 1'b1;
    else
      bready_i = 1'b1;
    @(negedge clk_i);
    rready_i = 1'b0;
    bready_i = 1'b0;
  endtask

  task automatic axi_write(input logic [11:0] id, input logic [31:0] addr,
      input logic [31:0] data, input logic [3:0] strb, input int stall);
    logic [31:0] exp_data;
    logic [1:0] exp_resp;
    ref_access(1'b1, addr, data, strb, exp_data, exp_resp);
    @(negedge clk_i);
    awid_i = id;
    awaddr_i = addr;
    wdata_i = data;
    wstrb_i = strb;
    awvalid_i = 1'b1;
    wvalid_i = 1'b1;
    wait_ready(1'b0, "awready and wready");
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i = 1'b0;
    wait_resp(1'b0, id, exp_data, exp_resp, stall);
  endtask

  task automatic axi_read(input logic [11:0] id, input logic [31:0] addr, input int stall);
    logic [31:0] exp_data;
    logic [1:0] exp_resp;
    ref_access(1'b0, addr, 32'h0, 4'h0, exp_data, exp_resp);
    @(negedge clk_i);
    arid_i = id;
    araddr_i = addr;
    arvalid_i = 1'b1;
    wait_ready(1'b1, "arready");
    @(negedge clk_i);
    arvalid_i = 1'b0;
    wait_resp(1'b1, id, exp_data, exp_resp, stall);
  endtask

  // Waits for the compare process to empty the queue and then reports
  task automatic finish_test(input string name, inout int err_mark, inout int chk_mark);
    int n;
    n = 0;
    while (q_exp.size() > 0) begin
      n++;
      if (n > TIMEOUT)
        timeout_abort("drain of the compare queue");
      @(negedge clk_i);
    end
    $display("[%0d ns] %s: %0d checks, %0d errors", $time, name,
             checks - chk_mark, errors - err_mark);
    err_mark = errors;
    chk_mark = checks;
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  always @(posedge clk_i) begin
    string w;
    logic [31:0] e;
    logic [31:0] g;
    while (q_exp.size() > 0) begin
      w = q_what.pop_front();
      e = q_exp.pop_front();
      g = q_got.pop_front();
      checks++;
      assert (e === g) else begin
        errors++;
        $display("Error at %0d ns: %s, expected %h, got %h", $time, w, e, g);
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int i, r, n, err_mark, chk_mark;
    logic [31:0] data, exp_data;
    logic [3:0] strb;
    logic [1:0] exp_resp;
    logic seen_b;
    seed = 61;
    checks = 0;
    errors = 0;
    err_mark = 0;
    chk_mark = 0;
    m_scratch = '0;
    m_led = '0;
    rst_i = 1'b1;
    awid_i = '0;
    awaddr_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    wvalid_i = 1'b0;
    bready_i = 1'b0;
    arid_i = '0;
    araddr_i = '0;
    arvalid_i = 1'b0;
    rready_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;

    // 1. Quiet outputs then ID and scratch reset values
    @(negedge clk_i);
    queue_check("ready and valid after reset", 32'd0,
                32'({awready_o, wready_o, arready_o, bvalid_o, rvalid_o}));
    queue_check("led_o after reset", 32'd0, 32'(led_o));
    axi_read(12'h001, hk_addr(3'd0, OFF_ID), 0);
    axi_read(12'h002, hk_addr(3'd0, OFF_SCRATCH), 0);
    finish_test("reset state", err_mark, chk_mark);

    // 2. Full-word scratch write and read back
    for (i = 0; i < 8; i++) begin
      data = $random(seed);
      axi_write(12'($random(seed)), hk_addr(3'd0, OFF_SCRATCH), data, 4'hf, 0);
      axi_read(12'($random(seed)), hk_addr(3'd0, OFF_SCRATCH), 0);
    end
    finish_test("scratch full words", err_mark, chk_mark);

    // 3. Byte strobes on scratch and lane 0 on LED
    for (i = 0; i < 8; i++) begin
      data = $random(seed);
      strb = 4'($random(seed));
      axi_write(12'(i), hk_addr(3'd0, OFF_SCRATCH), data, strb, 0);
      axi_read(12'(i + 16), hk_addr(3'd0, OFF_SCRATCH), 0);
    end
    for (i = 0; i < 6; i++) begin
      data = $random(seed);
      strb = {3'($random(seed)), i[0]};
      axi_write(12'(i + 32), hk_addr(3'd0, OFF_LED), data, strb, 0);
      queue_check("led_o", 32'(m_led), 32'(led_o));
      axi_read(12'(i + 48), hk_addr(3'd0, OFF_LED), 0);
    end
    finish_test("byte strobes and LED", err_mark, chk_mark);

    // 4. Unmapped regions error out
    // Scratch data left on the region 0 read path
    axi_read(12'h09f, hk_addr(3'd0, OFF_SCRATCH), 0);
    for (r = 1; r < 8; r++) begin
      data = $random(seed);
      axi_write(12'(r), hk_addr(3'(r), OFF_SCRATCH), data, 4'hf, 0);
      axi_read(12'(r + 8), hk_addr(3'(r), OFF_SCRATCH), 0);
    end
    axi_read(12'h0a0, hk_addr(3'd0, OFF_SCRATCH), 0);
    // Holes in region 0 read zero and drop writes
    axi_write(12'h0a1, hk_addr(3'd0, 20'h00010), 32'hdead_beef, 4'hf, 0);
    axi_read(12'h0a2, hk_addr(3'd0, 20'h00010), 0);
    axi_read(12'h0a3, hk_addr(3'd0, OFF_SCRATCH), 0);
    finish_test("unmapped accesses", err_mark, chk_mark);

    // 5. Back-pressure on B and R
    for (i = 0; i < 6; i++) begin
      data = $random(seed);
      axi_write(12'(i + 64), hk_addr(3'd0, OFF_SCRATCH), data, 4'hf, rand_stall());
      axi_read(12'(i + 80), hk_addr(3'd0, OFF_SCRATCH), rand_stall());
    end
    axi_read(12'h3ff, hk_addr(3'd0, OFF_ID), 0);
    finish_test("response back-pressure", err_mark, chk_mark);

    // 6. Write goes first when offered with a read in one cycle
    data = $random(seed);
    ref_access(1'b1, hk_addr(3'd0, OFF_SCRATCH), data, 4'hf, exp_data, exp_resp);
    @(negedge clk_i);
    awid_i = 12'h5a1;
    arid_i = 12'h5a2;
    awaddr_i = hk_addr(3'd0, OFF_SCRATCH);
    araddr_i = hk_addr(3'd0, OFF_SCRATCH);
    wdata_i = data;
    wstrb_i = 4'hf;
    awvalid_i = 1'b1;
    wvalid_i = 1'b1;
    arvalid_i = 1'b1;
    wait_ready(1'b0, "awready and wready");
    queue_check("arready during write handshake", 32'd0, 32'(arready_o));
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i = 1'b0;
    bready_i = 1'b1;
    // Read stays offered while the write finishes
    n = 0;
    seen_b = 1'b0;
    #2;
    while (!arready_o) begin
      if (bvalid_o) begin
        seen_b = 1'b1;
        queue_check("response id", 32'h5a1, 32'(bid_o));
        queue_check("response code", 32'(exp_resp), 32'(bresp_o));
      end
      n++;
      if (n > TIMEOUT)
        timeout_abort("arready after the write");
      @(negedge clk_i);
      #2;
    end
    queue_check("write response before read", 32'd1, 32'(seen_b));
    ref_access(1'b0, hk_addr(3'd0, OFF_SCRATCH), 32'h0, 4'h0, exp_data, exp_resp);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    bready_i = 1'b0;
    wait_resp(1'b1, 12'h5a2, exp_data, exp_resp, 0);
    finish_test("write wins over read", err_mark, chk_mark);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/rp_ps_bus.sv
/*
 * PS bus subsystem top level
 * AXI slave bridge, region decoder and housekeeping registers
 */

`include "rp_params.svh"

module rp_ps_bus (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Write address
  input  logic [`RP_IW-1:0]      awid_i,
  input  logic [`RP_AW-1:0]      awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  // Write data
  input  logic [`RP_DW-1:0]      wdata_i,
  input  logic [`RP_DW/8-1:0]    wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  // Write response
  output logic [`RP_IW-1:0]      bid_o,
  output rp_axi_pkg::axi_resp_t  bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  // Read address
  input  logic [`RP_IW-1:0]      arid_i,
  input  logic [`RP_AW-1:0]      araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  // Read data
  output logic [`RP_IW-1:0]      rid_o,
  output logic [`RP_DW-1:0]      rdata_o,
  output rp_axi_pkg::axi_resp_t  rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  // Board LEDs
  output logic [`RP_LED_W-1:0]   led_o
);

  // Bridge to decoder, decoder to region 0
  sys_bus_if bus ();
  sys_bus_if hk ();

  axi_slave_bridge i_bridge (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rid_o     (rid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .bus       (bus)
  );

  sys_bus_decode i_decode (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (bus),
    .hk    (hk)
  );

  hk_regs i_hk (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (hk),
    .led_o (led_o)
  );

endmodule

// File: verilog/hk_regs.sv
/*
 * Housekeeping register bank
 * ID word, byte-writable scratch word and LED register
 */

`include "rp_params.svh"

module hk_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // System bus slave, offset in the low address bits
  sys_bus_if.s                 bus,
  output logic [`RP_LED_W-1:0] led_o
);

  rp_sys_pkg::hk_addr_t  offset;
  logic [`RP_DW-1:0]     scratch_q;
  logic [`RP_LED_W-1:0]  led_q;
  logic [`RP_DW-1:0]     rdata_q;
  logic                  ack_q;

  assign offset = rp_sys_pkg::hk_addr_t'(bus.addr[`RP_REG_LSB-1:0]);

  ////////////////////
  // Register writes
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch_q <= `RP_HK_SCRATCH_RST;
      led_q     <= `RP_HK_LED_RST;
    end else if (bus.wen) begin
      case (offset)
        rp_sys_pkg::HK_SCRATCH: begin
          // Byte lanes under sel
          for (int b = 0; b < `RP_DW/8; b++) begin
            if (bus.sel[b]) scratch_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        rp_sys_pkg::HK_LED: begin
          // First lane only
          if (bus.sel[0]) led_q <= bus.wdata[`RP_LED_W-1:0];
        end
        // ID is read-only, unknown offsets drop the write
        default: ;
      endcase
    end
  end

  ////////////////////
  // Read and ack
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (bus.ren) begin
      case (offset)
        rp_sys_pkg::HK_ID:      rdata_q <= `RP_HK_ID;
        rp_sys_pkg::HK_SCRATCH: rdata_q <= scratch_q;
        rp_sys_pkg::HK_LED:     rdata_q <= {{(`RP_DW - `RP_LED_W){1'b0}}, led_q};
        // Holes in the map read as zero
        default:                rdata_q <= '0;
      endcase
    end
  end

  // Every strobe is answered next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) ack_q <= 1'b0;
    else ack_q <= bus.wen || bus.ren;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.rdata = rdata_q;

  assign led_o = led_q;

endmodule

// File: verilog/sys_bus_decode.sv
/*
 * System bus region decoder
 * Region 0 goes to the housekeeping bank, others answer with an error
 */

`include "rp_params.svh"

module sys_bus_decode (
  input  logic  clk_i,
  input  logic  rst_i,
  // From the bridge
  sys_bus_if.s  bus,
  // To the housekeeping registers
  sys_bus_if.m  hk
);

  rp_sys_pkg::region_t region;
  logic                hk_hit;
  logic                un_ack_q;
  logic                hk_busy_q;

  // Region from address bits 22:20
  assign region = rp_sys_pkg::region_t'(bus.addr[`RP_REG_MSB:`RP_REG_LSB]);
  assign hk_hit = (region == rp_sys_pkg::REG_HK);

  ////////////////////
  // Region 0 path
  ////////////////////

  // Only the in-region offset reaches the bank
  assign hk.addr  = {{(`RP_AW - `RP_REG_LSB){1'b0}}, bus.addr[`RP_REG_LSB-1:0]};
  assign hk.wdata = bus.wdata;
  assign hk.sel   = bus.sel;
  assign hk.wen   = bus.wen && hk_hit;
  assign hk.ren   = bus.ren && hk_hit;

  ////////////////////
  // Unmapped regions
  ////////////////////

  // Error ack one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) un_ack_q <= 1'b0;
    else un_ack_q <= (bus.wen || bus.ren) && !hk_hit;
  end

  // Merge responses, unmapped reads give zero
  assign bus.ack   = hk.ack || un_ack_q;
  assign bus.err   = un_ack_q ? 1'b1 : hk.err;
  assign bus.rdata = un_ack_q ? '0 : hk.rdata;

  ////////////////////
  // Checks
  ////////////////////

  // Outstanding region 0 access, strobe until ack
  always_ff @(posedge clk_i) begin
    if (rst_i) hk_busy_q <= 1'b0;
    else if (hk.wen || hk.ren) hk_busy_q <= 1'b1;
    else if (hk.ack) hk_busy_q <= 1'b0;
  end

  a_hk_ack_owned: assert property (@(posedge clk_i) disable iff (rst_i)
    hk.ack |-> hk_busy_q)
    else $error("decode: housekeeping ack without an access");

endmodule

// File: verilog/axi_slave_bridge.sv
/*
 * Single-beat AXI slave to system bus bridge
 * Takes AW and W together, then issues one strobe and waits for ack
 * Holds the B or R response until the master accepts it
 */

`include "rp_params.svh"

module axi_slave_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Write address
  input  logic [`RP_IW-1:0]      awid_i,
  input  logic [`RP_AW-1:0]      awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  // Write data
  input  logic [`RP_DW-1:0]      wdata_i,
  input  logic [`RP_DW/8-1:0]    wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  // Write response
  output logic [`RP_IW-1:0]      bid_o,
  output rp_axi_pkg::axi_resp_t  bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  // Read address
  input  logic [`RP_IW-1:0]      arid_i,
  input  logic [`RP_AW-1:0]      araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  // Read data
  output logic [`RP_IW-1:0]      rid_o,
  output logic [`RP_DW-1:0]      rdata_o,
  output rp_axi_pkg::axi_resp_t  rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  // System bus master
  sys_bus_if.m                   bus
);

  rp_axi_pkg::bridge_state_t state_q;
  rp_axi_pkg::bridge_state_t state_d;

  logic                  wr_go;
  logic                  rd_go;
  logic                  waiting;
  logic [`RP_IW-1:0]     id_q;
  logic [`RP_AW-1:0]     addr_q;
  logic [`RP_DW-1:0]     wdata_q;
  logic [`RP_DW/8-1:0]   sel_q;
  logic [`RP_DW-1:0]     rdata_q;
  rp_axi_pkg::axi_resp_t resp_q;

  ////////////////////
  // AXI handshakes
  ////////////////////

  // Write needs address and data in the same cycle
  assign wr_go = (state_q == rp_axi_pkg::IDLE) && awvalid_i && wvalid_i;
  // Read only when no complete write is offered, write wins a tie
  assign rd_go = (state_q == rp_axi_pkg::IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  // Strobe issued, ack not yet seen
  assign waiting = (state_q == rp_axi_pkg::WR_REQ) || (state_q == rp_axi_pkg::WR_WAIT) ||
                   (state_q == rp_axi_pkg::RD_REQ) || (state_q == rp_axi_pkg::RD_WAIT);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      rp_axi_pkg::IDLE: begin
        if (wr_go) state_d = rp_axi_pkg::WR_REQ;
        else if (rd_go) state_d = rp_axi_pkg::RD_REQ;
      end
      // Ack may come with the strobe from a fast slave
      rp_axi_pkg::WR_REQ:  state_d = bus.ack ? rp_axi_pkg::WR_RESP : rp_axi_pkg::WR_WAIT;
      rp_axi_pkg::WR_WAIT: if (bus.ack) state_d = rp_axi_pkg::WR_RESP;
      rp_axi_pkg::WR_RESP: if (bready_i) state_d = rp_axi_pkg::IDLE;
      rp_axi_pkg::RD_REQ:  state_d = bus.ack ? rp_axi_pkg::RD_RESP : rp_axi_pkg::RD_WAIT;
      rp_axi_pkg::RD_WAIT: if (bus.ack) state_d = rp_axi_pkg::RD_RESP;
      rp_axi_pkg::RD_RESP: if (rready_i) state_d = rp_axi_pkg::IDLE;
      default:             state_d = rp_axi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= rp_axi_pkg::IDLE;
    else state_q <= state_d;
  end

  // Request capture at the handshake
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      id_q    <= awid_i;
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      sel_q   <= wstrb_i;
    end else if (rd_go) begin
      id_q    <= arid_i;
      addr_q  <= araddr_i;
    end
  end

  // Response capture on ack
  always_ff @(posedge clk_i) begin
    if (waiting && bus.ack) begin
      resp_q  <= bus.err ? rp_axi_pkg::SLVERR : rp_axi_pkg::OKAY;
      rdata_q <= bus.rdata;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Strobes last exactly one cycle, the REQ states
  assign bus.wen   = (state_q == rp_axi_pkg::WR_REQ);
  assign bus.ren   = (state_q == rp_axi_pkg::RD_REQ);
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.sel   = sel_q;

  assign bvalid_o = (state_q == rp_axi_pkg::WR_RESP);
  assign bid_o    = id_q;
  assign bresp_o  = resp_q;

  assign rvalid_o = (state_q == rp_axi_pkg::RD_RESP);
  assign rid_o    = id_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;

  ////////////////////
  // Checks
  ////////////////////

  a_one_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    !(bus.wen && bus.ren))
    else $error("bridge: wen and ren high together");

  // No new bus access while the master still owes us a ready
  a_no_strobe_in_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    (bvalid_o || rvalid_o) |-> !(bus.wen || bus.ren))
    else $error("bridge: strobe issued with a response pending");

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bid_o) && $stable(bresp_o)))
    else $error("bridge: write response dropped before bready");

endmodule

// File: verilog/sys_bus_if.sv
/*
 * Simple system bus between bridge, decoder and register bank
 */

`include "rp_params.svh"

interface sys_bus_if;

  // Request side, held from strobe until ack
  logic [`RP_AW-1:0]   addr;
  logic [`RP_DW-1:0]   wdata;
  logic [`RP_DW/8-1:0] sel;
  // One-cycle strobes
  logic                wen;
  logic                ren;

  // Response side, valid with ack
  logic [`RP_DW-1:0]   rdata;
  logic                ack;
  logic                err;

  // Bus master
  modport m (
    output addr, wdata, sel, wen, ren,
    input  rdata, ack, err
  );

  // Bus slave
  modport s (
    input  addr, wdata, sel, wen, ren,
    output rdata, ack, err
  );

endinterface

// File: verilog/rp_sys_pkg.sv
/*
 * System bus side types
 * Region codes from the upper address bits
 * Housekeeping register offsets
 */

package rp_sys_pkg;

  ////////////////////
  // Bus regions
  ////////////////////

  // Address bits 22:20, only region 0 is populated
  typedef enum logic [2:0] {
    REG_HK        = 3'd0,
    REG_UNMAPPED1 = 3'd1,
    REG_UNMAPPED2 = 3'd2,
    REG_UNMAPPED3 = 3'd3,
    REG_UNMAPPED4 = 3'd4,
    REG_UNMAPPED5 = 3'd5,
    REG_UNMAPPED6 = 3'd6,
    REG_UNMAPPED7 = 3'd7
  } region_t;

  ////////////////////
  // Housekeeping map
  ////////////////////

  // Byte offsets inside region 0
  typedef enum logic [19:0] {
    // Read-only identification word
    HK_ID      = 20'h00000,
    // General purpose, byte writable
    HK_SCRATCH = 20'h00004,
    // Board LEDs in the low byte
    HK_LED     = 20'h00008
  } hk_addr_t;

endpackage

// File: verilog/rp_axi_pkg.sv
/*
 * AXI side types for the PS bus bridge
 * Response codes and bridge FSM states
 */

package rp_axi_pkg;

  ////////////////////
  // AXI response
  ////////////////////

  // Only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  ////////////////////
  // Bridge FSM
  ////////////////////

  // One transaction in flight, write or read
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    // Write path
    WR_REQ  = 3'd1,
    WR_WAIT = 3'd2,
    WR_RESP = 3'd3,
    // Read path
    RD_REQ  = 3'd4,
    RD_WAIT = 3'd5,
    RD_RESP = 3'd6
  } bridge_state_t;

endpackage

// File: verilog/rp_params.svh
/*
 * Bus widths, region field and housekeeping constants
 */

`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

// Bus widths
`define RP_AW 32
`define RP_DW 32

// AXI ID from the GP0 port
`define RP_IW 12

// Region select field in the address
`define RP_REG_LSB 20
`define RP_REG_MSB 22

// Housekeeping ID word, "RP" plus revision
`define RP_HK_ID 32'h5250_0001

// Reset values of the writable registers
`define RP_HK_SCRATCH_RST 32'h0000_0000
`define RP_LED_W 8
`define RP_HK_LED_RST 8'h00

`endif
